//--- Bender.yml
package:
  name: pito_lite

sources:
  # RTL in compile order
  - design/pito_pkg.sv
  - design/pito_fetch.sv
  - design/pito_decode.sv
  - design/pito_regfile.sv
  - design/pito_execute.sv
  - design/pito_retire.sv
  - design/pito_core.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/pito_core_assertions.sv
      - test/pito_core_tb.sv

//--- design/pito_core.sv
`timescale 1ns/100ps
`default_nettype none

module pito_core import pito_pkg::*; #(
    parameter int IMEM_DEPTH = 256,
    parameter int CREDITS    = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        prog_we,
    input  word_t       prog_addr,
    input  word_t       prog_data,
    input  logic        start,
    input  word_t       run_len,
    input  logic        credit_return,
    output logic        busy,
    output logic        retire_valid,
    output retire_rec_t retire_rec
);

    // ========================================================================
    // Stage links
    // ========================================================================
    logic        stall;
    fetch_out_t  fetch_out;
    reg_addr_t   rs1_addr;
    reg_addr_t   rs2_addr;
    word_t       rs1_val;
    word_t       rs2_val;
    dec_op_t     dec_op;
    retire_rec_t ex_rec;
    logic        ex_valid;
    logic        ex_writes_rd;
    // Register file write port
    logic        wr_en;
    reg_addr_t   wr_addr;
    word_t       wr_data;
    // Retire to execute bypass
    logic        fwd_valid;
    reg_addr_t   fwd_rd;
    word_t       fwd_value;

    pito_fetch #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_fetch (
        .clk        (clk),
        .reset      (reset),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .start      (start),
        .run_len    (run_len),
        .stall      (stall),
        .retire_fire(retire_valid),
        .busy       (busy),
        .fetch_out  (fetch_out)
    );

    pito_decode u_decode (
        .clk     (clk),
        .reset   (reset),
        .stall   (stall),
        .fetch_in(fetch_out),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .dec_out (dec_op)
    );

    pito_regfile u_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs1_addr(rs1_addr),
        .rs2_addr(rs2_addr),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val)
    );

    pito_execute u_execute (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .dec_in      (dec_op),
        .fwd_valid   (fwd_valid),
        .fwd_rd      (fwd_rd),
        .fwd_value   (fwd_value),
        .ex_out      (ex_rec),
        .ex_valid    (ex_valid),
        .ex_writes_rd(ex_writes_rd)
    );

    pito_retire #(
        .CREDITS(CREDITS)
    ) u_retire (
        .clk          (clk),
        .reset        (reset),
        .ex_in        (ex_rec),
        .ex_valid     (ex_valid),
        .ex_writes_rd (ex_writes_rd),
        .credit_return(credit_return),
        .stall        (stall),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .fwd_valid    (fwd_valid),
        .fwd_rd       (fwd_rd),
        .fwd_value    (fwd_value)
    );

endmodule

`default_nettype wire

//--- design/pito_decode.sv
`timescale 1ns/100ps
`default_nettype none

module pito_decode import pito_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall,
    input  fetch_out_t fetch_in,
    input  word_t      rs1_val,
    input  word_t      rs2_val,
    output reg_addr_t  rs1_addr,
    output reg_addr_t  rs2_addr,
    output dec_op_t    dec_out
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_u;
    word_t      shamt;
    dec_op_t    dec_next;

    // ========================================================================
    // Field extraction
    // ========================================================================
    assign opcode   = fetch_in.instr[6:0];
    assign funct3   = fetch_in.instr[14:12];
    assign funct7   = fetch_in.instr[31:25];
    assign rs1_addr = fetch_in.instr[19:15];
    assign rs2_addr = fetch_in.instr[24:20];

    assign imm_i = {{20{fetch_in.instr[31]}}, fetch_in.instr[31:20]};
    assign imm_u = {fetch_in.instr[31:12], 12'b0};
    assign shamt = {27'b0, fetch_in.instr[24:20]};

    // ========================================================================
    // ALU operation select
    // ========================================================================
    always_comb begin
        dec_next           = '0;
        dec_next.valid     = fetch_in.valid;
        dec_next.pc        = fetch_in.pc;
        dec_next.rd        = fetch_in.instr[11:7];
        dec_next.rs1       = rs1_addr;
        dec_next.rs2       = rs2_addr;
        dec_next.rs1_val   = rs1_val;
        dec_next.rs2_val   = rs2_val;
        dec_next.imm       = imm_i;
        dec_next.alu_op    = ALU_ADD;
        dec_next.writes_rd = 1'b1;
        case (opcode)
            OPC_OP: begin
                case ({funct7, funct3})
                    {7'h00, 3'b000}: dec_next.alu_op = ALU_ADD;
                    {7'h20, 3'b000}: dec_next.alu_op = ALU_SUB;
                    {7'h00, 3'b001}: dec_next.alu_op = ALU_SLL;
                    {7'h00, 3'b010}: dec_next.alu_op = ALU_SLT;
                    {7'h00, 3'b011}: dec_next.alu_op = ALU_SLTU;
                    {7'h00, 3'b100}: dec_next.alu_op = ALU_XOR;
                    {7'h00, 3'b101}: dec_next.alu_op = ALU_SRL;
                    {7'h20, 3'b101}: dec_next.alu_op = ALU_SRA;
                    {7'h00, 3'b110}: dec_next.alu_op = ALU_OR;
                    {7'h00, 3'b111}: dec_next.alu_op = ALU_AND;
                    default:         dec_next.illegal = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                dec_next.use_imm = 1'b1;
                case (funct3)
                    3'b000: dec_next.alu_op = ALU_ADD;
                    3'b010: dec_next.alu_op = ALU_SLT;
                    3'b011: dec_next.alu_op = ALU_SLTU;
                    3'b100: dec_next.alu_op = ALU_XOR;
                    3'b110: dec_next.alu_op = ALU_OR;
                    3'b111: dec_next.alu_op = ALU_AND;
                    // Shifts take shamt, upper bits must match the encoding
                    3'b001: begin
                        dec_next.imm     = shamt;
                        dec_next.alu_op  = ALU_SLL;
                        dec_next.illegal = (funct7 != 7'h00);
                    end
                    default: begin
                        dec_next.imm     = shamt;
                        dec_next.alu_op  = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
                        dec_next.illegal = (funct7 != 7'h00) && (funct7 != 7'h20);
                    end
                endcase
            end
            OPC_LUI: begin
                dec_next.use_imm = 1'b1;
                dec_next.imm     = imm_u;
                dec_next.alu_op  = ALU_PASS_B;
            end
            default: dec_next.illegal = 1'b1;
        endcase
        // Illegal instructions never touch the register file
        if (dec_next.illegal) begin
            dec_next.writes_rd = 1'b0;
        end
    end

    // Decode stage register
    always_ff @(posedge clk) begin
        if (reset) begin
            dec_out <= '0;
        end else if (!stall) begin
            dec_out <= dec_next;
        end
    end

endmodule

`default_nettype wire

//--- design/pito_execute.sv
`timescale 1ns/100ps
`default_nettype none

module pito_execute import pito_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        stall,
    input  dec_op_t     dec_in,
    input  logic        fwd_valid,
    input  reg_addr_t   fwd_rd,
    input  word_t       fwd_value,
    output retire_rec_t ex_out,
    output logic        ex_valid,
    output logic        ex_writes_rd
);

    logic  fwd_rs1;
    logic  fwd_rs2;
    word_t op_a;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_res;

    // Retire stage result overrides the value read in decode
    assign fwd_rs1 = fwd_valid && (fwd_rd != '0) && (fwd_rd == dec_in.rs1);
    assign fwd_rs2 = fwd_valid && (fwd_rd != '0) && (fwd_rd == dec_in.rs2);
    assign op_a    = fwd_rs1 ? fwd_value : dec_in.rs1_val;
    assign rs2_fwd = fwd_rs2 ? fwd_value : dec_in.rs2_val;
    assign op_b    = dec_in.use_imm ? dec_in.imm : rs2_fwd;

    // ========================================================================
    // ALU
    // ========================================================================
    always_comb begin
        case (dec_in.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = word_t'($signed(op_a) >>> op_b[4:0]);
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = '0;
        endcase
    end

    // Control bits of the execute register
    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid     <= 1'b0;
            ex_writes_rd <= 1'b0;
        end else if (!stall) begin
            ex_valid     <= dec_in.valid;
            ex_writes_rd <= dec_in.valid && dec_in.writes_rd;
        end
    end

    // Illegal records carry a zero value
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_out.pc      <= dec_in.pc;
            ex_out.rd      <= dec_in.rd;
            ex_out.value   <= dec_in.illegal ? '0 : alu_res;
            ex_out.illegal <= dec_in.illegal;
        end
    end

endmodule

`default_nettype wire

//--- design/pito_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module pito_fetch import pito_pkg::*; #(
    parameter int IMEM_DEPTH = 256
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       prog_we,
    input  word_t      prog_addr,
    input  word_t      prog_data,
    input  logic       start,
    input  word_t      run_len,
    input  logic       stall,
    input  logic       retire_fire,
    output logic       busy,
    output fetch_out_t fetch_out
);

    localparam int AW = $clog2(IMEM_DEPTH);

    word_t      imem [IMEM_DEPTH];
    pc_t        pc;
    // Instructions still to be fetched in this run
    word_t      remaining;
    // Fetched but not yet issued from retire, at most one per stage
    logic [2:0] inflight;
    logic       fetch_fire;

    assign fetch_fire = (remaining != '0) && !stall;
    assign busy       = (remaining != '0) || (inflight != '0);

    // Program port, byte addressed like the pc
    always_ff @(posedge clk) begin
        if (prog_we && !busy) begin
            imem[prog_addr[AW+1:2]] <= prog_data;
        end
    end

    // ========================================================================
    // PC and run control
    // ========================================================================
    always_ff @(posedge clk) begin
        if (reset) begin
            pc        <= '0;
            remaining <= '0;
            inflight  <= '0;
            fetch_out <= '0;
        end else begin
            // New run always starts from address 0
            if (start && !busy) begin
                pc        <= '0;
                remaining <= run_len;
            end else if (fetch_fire) begin
                pc        <= pc + 32'd4;
                remaining <= remaining - 32'd1;
            end
            // Synchronous read, one cycle from pc to fetch_out
            if (!stall) begin
                fetch_out.valid <= fetch_fire;
                fetch_out.pc    <= pc;
                fetch_out.instr <= imem[pc[AW+1:2]];
            end
            inflight <= inflight + 3'(fetch_fire) - 3'(retire_fire);
        end
    end

endmodule

`default_nettype wire

//--- design/pito_pkg.sv
`default_nettype none

package pito_pkg;

    // ========================================================================
    // Widths and base types
    // ========================================================================
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    // Byte address, always word aligned
    typedef logic [XLEN-1:0]       pc_t;

    // ALU operations
    // PASS_B forwards operand B unchanged, used for LUI
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_t;

    // Major opcodes kept by this core
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    // ========================================================================
    // Stage records
    // ========================================================================

    // Fetch to decode
    typedef struct packed {
        logic  valid;
        pc_t   pc;
        word_t instr;
    } fetch_out_t;

    // Decode to execute
    typedef struct packed {
        logic      valid;
        pc_t       pc;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_val;
        word_t     rs2_val;
        // I-type immediate, U-type immediate or zero-extended shamt
        word_t     imm;
        logic      use_imm;
        logic      writes_rd;
        logic      illegal;
        alu_op_t   alu_op;
    } dec_op_t;

    // Execute to retire, and the outgoing retire stream
    typedef struct packed {
        pc_t       pc;
        reg_addr_t rd;
        word_t     value;
        logic      illegal;
    } retire_rec_t;

endpackage

`default_nettype wire

//--- design/pito_regfile.sv
`timescale 1ns/100ps
`default_nettype none

module pito_regfile import pito_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data,
    output word_t     rs1_val,
    output word_t     rs2_val
);

    word_t regs [32];

    // Entry 0 is never written
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Reads see a same-cycle write, x0 stays zero
    assign rs1_val = (rs1_addr == '0) ? '0 :
                     (wr_en && (wr_addr == rs1_addr)) ? wr_data : regs[rs1_addr];
    assign rs2_val = (rs2_addr == '0) ? '0 :
                     (wr_en && (wr_addr == rs2_addr)) ? wr_data : regs[rs2_addr];

endmodule

`default_nettype wire

//--- design/pito_retire.sv
`timescale 1ns/100ps
`default_nettype none

module pito_retire import pito_pkg::*; #(
    parameter int CREDITS = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  retire_rec_t ex_in,
    input  logic        ex_valid,
    input  logic        ex_writes_rd,
    input  logic        credit_return,
    output logic        stall,
    output logic        retire_valid,
    output retire_rec_t retire_rec,
    output logic        wr_en,
    output reg_addr_t   wr_addr,
    output word_t       wr_data,
    output logic        fwd_valid,
    output reg_addr_t   fwd_rd,
    output word_t       fwd_value
);

    localparam int CW = $clog2(CREDITS + 1);

    logic          ret_valid;
    logic          ret_writes_rd;
    retire_rec_t   ret_rec;
    logic [CW-1:0] credits;

    // Whole pipeline freezes while a record waits for a credit
    assign stall        = ret_valid && (credits == '0);
    assign retire_valid = ret_valid && !stall;
    assign retire_rec   = ret_rec;

    // Register file write happens together with the issue
    assign wr_en   = retire_valid && ret_writes_rd;
    assign wr_addr = ret_rec.rd;
    assign wr_data = ret_rec.value;

    // Forwarding path to execute
    assign fwd_valid = ret_valid && ret_writes_rd;
    assign fwd_rd    = ret_rec.rd;
    assign fwd_value = ret_rec.value;

    always_ff @(posedge clk) begin
        if (reset) begin
            ret_valid     <= 1'b0;
            ret_writes_rd <= 1'b0;
            credits       <= CW'(CREDITS);
        end else begin
            if (!stall) begin
                ret_valid     <= ex_valid;
                ret_writes_rd <= ex_writes_rd;
            end
            // One credit out per issued record, one back per return
            credits <= credits - CW'(retire_valid) + CW'(credit_return);
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            ret_rec <= ex_in;
        end
    end

endmodule

`default_nettype wire

//--- pito_lite.f
design/pito_pkg.sv
design/pito_fetch.sv
design/pito_decode.sv
design/pito_regfile.sv
design/pito_execute.sv
design/pito_retire.sv
design/pito_core.sv
test/pito_core_assertions.sv
test/pito_core_tb.sv

//--- test/pito_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module pito_core_assertions #(
    parameter int CREDITS = 4
) (
    input logic                           clk,
    input logic                           reset,
    input logic                           busy,
    input logic                           retire_valid,
    input logic                           credit_return,
    input logic [$clog2(CREDITS+1)-1:0]   credits
);

    // Records issued to the consumer and not yet returned
    int outstanding;
    // Count of failed assertions, watched by the testbench
    int failures = 0;

    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(retire_valid) - int'(credit_return);
        end
    end

    // ========================================================================
    // Credit protocol
    // ========================================================================
    outstanding_bounded: assert property (
        @(posedge clk) disable iff (reset) outstanding <= CREDITS
    ) else begin
        $error("more records outstanding than credits");
        failures++;
    end

    // No issue while the consumer already holds every credit
    no_issue_without_credit: assert property (
        @(posedge clk) disable iff (reset) retire_valid |-> (outstanding < CREDITS)
    ) else begin
        $error("record issued with zero credits");
        failures++;
    end

    // One cycle after reset the core is idle with a full credit count
    reset_state: assert property (
        @(posedge clk) reset |=> (!busy && !retire_valid && (credits == CREDITS))
    ) else begin
        $error("core not idle after reset");
        failures++;
    end

endmodule

`default_nettype wire

//--- test/pito_core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module pito_core_tb import pito_pkg::*; ();

    localparam int IMEM_DEPTH = 256;
    localparam int CREDITS    = 4;
    // Trace lines and words per line
    localparam int TRACE_MAX  = 64;
    localparam int FIELDS     = 6;

    localparam word_t KIND_END   = 32'h0;
    localparam word_t KIND_INSTR = 32'h1;
    localparam word_t KIND_RUN   = 32'h2;

    logic        clk;
    logic        reset;
    logic        prog_we;
    word_t       prog_addr;
    word_t       prog_data;
    logic        start;
    word_t       run_len;
    logic        credit_return;
    logic        busy;
    logic        retire_valid;
    retire_rec_t retire_rec;

    word_t       trace [TRACE_MAX*FIELDS];
    // Records still to come, in program order
    retire_rec_t expect_q [$];
    // Records received and not yet handed back as credits
    int          pending_credits;
    int          watchdog_cycles;
    logic [31:0] lfsr;

    pito_core #(
        .IMEM_DEPTH(IMEM_DEPTH),
        .CREDITS   (CREDITS)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .prog_we      (prog_we),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .start        (start),
        .run_len      (run_len),
        .credit_return(credit_return),
        .busy         (busy),
        .retire_valid (retire_valid),
        .retire_rec   (retire_rec)
    );

    bind pito_core pito_core_assertions #(
        .CREDITS(CREDITS)
    ) u_assertions (
        .clk          (clk),
        .reset        (reset),
        .busy         (busy),
        .retire_valid (retire_valid),
        .credit_return(credit_return),
        .credits      (u_retire.credits)
    );

    // Galois form with polynomial x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input word_t got, input word_t want);
        if (got !== want) begin
            abort_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want));
        end
    endtask

    // One word per cycle and prog_we stays high until the run starts
    task automatic load_word(input word_t addr, input word_t data);
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = addr;
        prog_data = data;
    endtask

    task automatic start_run(input word_t len);
        @(negedge clk);
        prog_we = 1'b0;
        start   = 1'b1;
        run_len = len;
        @(negedge clk);
        start   = 1'b0;
        // Done once busy drops and every queued record came back
        while (busy || (expect_q.size() != 0)) begin
            @(negedge clk);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ========================================================================
    // Retire monitor and credit return
    // ========================================================================
    always @(posedge clk) begin
        retire_rec_t want;
        if (!reset && retire_valid) begin
            if (expect_q.size() == 0) begin
                abort_run("A retire record arrived that the trace does not expect");
            end else begin
                want = expect_q.pop_front();
                check_value("retire_rec.pc", retire_rec.pc, want.pc);
                check_value("retire_rec.rd", 32'(retire_rec.rd), 32'(want.rd));
                check_value("retire_rec.value", retire_rec.value, want.value);
                check_value("retire_rec.illegal", 32'(retire_rec.illegal), 32'(want.illegal));
                pending_credits++;
            end
        end
    end

    // One LFSR bit per cycle, so credits pile up and stall the core
    always @(negedge clk) begin
        lfsr = lfsr_step(lfsr);
        if (!reset && lfsr[0] && (pending_credits > 0)) begin
            credit_return = 1'b1;
            pending_credits--;
        end else begin
            credit_return = 1'b0;
        end
    end

    // Stop at the first failed protocol assertion
    always @(negedge clk) begin
        if (DUT.u_assertions.failures != 0) begin
            abort_run("A credit protocol assertion failed");
        end
    end

    // Watchdog sized from the number of records in the trace
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        abort_run($sformatf("Timeout after %0d cycles, trace did not complete", watchdog_cycles));
    end

    // ========================================================================
    // Main sequence
    // ========================================================================
    initial begin
        int          idx;
        int          n_records;
        word_t       kind;
        retire_rec_t rec;
        reset           = 1'b1;
        prog_we         = 1'b0;
        prog_addr       = '0;
        prog_data       = '0;
        start           = 1'b0;
        run_len         = '0;
        credit_return   = 1'b0;
        pending_credits = 0;
        lfsr            = 32'h2653fbec;
        $readmemh("test/pito_trace.txt", trace);
        n_records = 0;
        for (idx = 0; idx < TRACE_MAX; idx++) begin
            if (trace[idx*FIELDS] === KIND_INSTR) begin
                n_records++;
            end
        end
        watchdog_cycles = 20 * n_records + 200;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        // Idle core, nothing may retire before start
        repeat (4) begin
            @(negedge clk);
            check_value("busy", 32'(busy), 32'h0);
            check_value("retire_valid", 32'(retire_valid), 32'h0);
        end
        idx  = 0;
        kind = trace[0];
        while ((idx < TRACE_MAX) && (kind !== KIND_END) && !$isunknown(kind)) begin
            case (kind)
                // Word goes to imem, its record to the queue
                KIND_INSTR: begin
                    load_word(trace[idx*FIELDS+1], trace[idx*FIELDS+2]);
                    rec.pc      = trace[idx*FIELDS+1];
                    rec.rd      = trace[idx*FIELDS+3][4:0];
                    rec.value   = trace[idx*FIELDS+4];
                    rec.illegal = trace[idx*FIELDS+5][0];
                    expect_q.push_back(rec);
                end
                KIND_RUN: start_run(trace[idx*FIELDS+1]);
                default: abort_run($sformatf("Trace line %0d has an unknown kind", idx));
            endcase
            idx++;
            if (idx < TRACE_MAX) begin
                kind = trace[idx*FIELDS];
            end
        end
        if (DUT.u_assertions.failures != 0) begin
            abort_run($sformatf("%0d assertion failures on the credit protocol",
                                DUT.u_assertions.failures));
        end else if (expect_q.size() != 0) begin
            abort_run("Trace ended with records that never retired");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- test/pito_trace.txt
// kind pc instr rd value illegal, all hex; kind 1 loads instr at pc and expects a record
// kind 2 runs pc-column words from address 0, kind 0 ends the trace
1 00000000 00500093 01 00000005 0
1 00000004 800001B7 03 80000000 0
1 00000008 FFD08113 02 00000002 0
1 0000000C 4041D213 04 F8000000 0
1 00000010 00309293 05 00000028 0
1 00000014 12300513 0A 00000123 0
1 00000018 40510333 06 FFFFFFDA 0
1 0000001C 0F01E613 0C 800000F0 0
1 00000020 401353B3 07 FFFFFFFE 0
1 00000024 0000A503 0A 00000000 1
1 00000028 0023B433 08 00000000 0
1 0000002C 007134B3 09 00000001 0
1 00000030 00050593 0B 00000123 0
1 00000034 00708013 00 0000000C 0
1 00000038 FFF00793 0F FFFFFFFF 0
1 0000003C 00000733 0E 00000000 0
1 00000040 40008833 10 00000005 0
2 00000011 00000000 00 00000000 0
// Second program overwrites the start of imem
1 00000000 12345A37 14 12345000 0
1 00000004 7FF08A93 15 00000804 0
1 00000008 678A6B13 16 12345678 0
1 0000000C FFF22B93 17 00000001 0
1 00000010 015B4C33 18 12345E7C 0
1 00000014 008B5C93 19 00123456 0
2 00000006 00000000 00 00000000 0
0 00000000 00000000 00 00000000 0
